/* common/card_pkg.sv */
package card_pkg;

	typedef logic [3:0] card_t;

	localparam card_t card_copper = 4'd0;
	localparam card_t card_estate = 4'd3;

	typedef logic [6:0] pile_addr_t;
	typedef logic [7:0] pile_size_t; // reaches 128 on a full pile

	localparam pile_size_t start_copper_count = 8'd7;
	localparam pile_size_t start_estate_count = 8'd3;

	localparam pile_size_t deck_depth = 8'd128; // discard pile is the same size
	localparam pile_size_t hand_depth = 8'd16;
	localparam pile_size_t hand_limit = 8'd5; // cards dealt per draw

	typedef enum logic [1:0] {
		pile_deck,
		pile_discard,
		pile_hand
	} pile_id_t;

	typedef enum logic [2:0] {
		cmd_new_game,
		cmd_buy,
		cmd_play,
		cmd_draw,
		cmd_endgame
	} cmd_code_t;

	// write puts literal data in the destination
	// move reads the source, then copies and/or emits it
	typedef enum logic {
		op_write,
		op_move
	} op_kind_t;

endpackage

/* common/pile_op_if.sv */
`timescale 1ns/1ps

interface pile_op_if
	import card_pkg::*;
();

	logic valid;
	logic ready;
	op_kind_t kind;
	pile_id_t src_pile;
	pile_addr_t src_addr;
	pile_id_t dst_pile;
	pile_addr_t dst_addr;
	logic copy; // move also writes the destination
	logic emit; // move also sends the card out
	card_t data; // literal for op_write

	modport seq (
		output valid, kind, src_pile, src_addr, dst_pile, dst_addr, copy, emit, data,
		input ready
	);

	modport store (
		input valid, kind, src_pile, src_addr, dst_pile, dst_addr, copy, emit, data,
		output ready
	);

endinterface

/* pile_store/card_pile.sv */
`timescale 1ns/1ps

module card_pile
	import card_pkg::*;
#(
	parameter int depth = deck_depth
) (
	input logic clk,
	input pile_addr_t rd_addr,
	output card_t rd_card,
	input logic wr_en,
	input pile_addr_t wr_addr,
	input card_t wr_card
);

	card_t mem [depth];

	// read returns the old word when the same address is written
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr[$clog2(depth)-1:0]] <= wr_card;
		end
		rd_card <= mem[rd_addr[$clog2(depth)-1:0]];
	end

endmodule

/* pile_store/pile_store.sv */
`timescale 1ns/1ps

module pile_store
	import card_pkg::*;
(
	input logic clk,
	input logic reset,
	pile_op_if.store op,
	output logic store_idle,
	output logic out_valid,
	input logic out_ready,
	output card_t out_card
);

	typedef struct packed {
		op_kind_t kind;
		pile_id_t src_pile;
		pile_addr_t src_addr;
		pile_id_t dst_pile;
		pile_addr_t dst_addr;
		logic copy;
		logic emit;
		card_t data;
	} stage_t;

	stage_t s1; // read stage
	stage_t s2; // write/emit stage
	logic s1_valid;
	logic s2_valid;
	logic s1_go;
	logic s2_go;
	logic s2_writes;
	logic fwd_hit;
	logic s2_fwd;
	card_t s2_fwd_card;
	pile_addr_t rd_addr;
	card_t deck_rd;
	card_t discard_rd;
	card_t hand_rd;
	card_t src_card;
	card_t s2_card;

	assign s2_go = s2_valid && (!s2.emit || out_ready); // emit waits for the buffer
	assign s1_go = s1_valid && (!s2_valid || s2_go);
	assign op.ready = !s1_valid || s1_go;
	assign s2_writes = (s2.kind == op_write) || s2.copy;

	// a stalled write stage keeps re-reading its own source
	assign rd_addr = (s2_valid && !s2_go) ? s2.src_addr : s1.src_addr;

	// write stage lands on the word the read stage is sampling this edge
	assign fwd_hit = s2_go && s2_writes && (s2.dst_pile == s1.src_pile) &&
		(s2.dst_addr == s1.src_addr);

	always_comb begin
		case (s2.src_pile)
			pile_deck: src_card = deck_rd;
			pile_discard: src_card = discard_rd;
			default: src_card = hand_rd;
		endcase
		if (s2.kind == op_write) begin
			s2_card = s2.data;
		end else if (s2_fwd) begin
			s2_card = s2_fwd_card;
		end else begin
			s2_card = src_card;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s2_fwd <= 1'b0;
		end else begin
			if (op.ready) begin
				s1_valid <= op.valid;
			end
			if (s1_go) begin
				s2_valid <= 1'b1;
				s2_fwd <= fwd_hit;
			end else if (s2_go) begin
				s2_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (op.valid && op.ready) begin
			s1 <= '{
				kind: op.kind,
				src_pile: op.src_pile,
				src_addr: op.src_addr,
				dst_pile: op.dst_pile,
				dst_addr: op.dst_addr,
				copy: op.copy,
				emit: op.emit,
				data: op.data
			};
		end
		if (s1_go) begin
			s2 <= s1;
			s2_fwd_card <= s2_card;
		end
	end

	card_pile #(.depth(deck_depth)) deck_i (
		.clk,
		.rd_addr,
		.rd_card(deck_rd),
		.wr_en(s2_go && s2_writes && (s2.dst_pile == pile_deck)),
		.wr_addr(s2.dst_addr),
		.wr_card(s2_card)
	);

	card_pile #(.depth(deck_depth)) discard_i (
		.clk,
		.rd_addr,
		.rd_card(discard_rd),
		.wr_en(s2_go && s2_writes && (s2.dst_pile == pile_discard)),
		.wr_addr(s2.dst_addr),
		.wr_card(s2_card)
	);

	card_pile #(.depth(hand_depth)) hand_i (
		.clk,
		.rd_addr,
		.rd_card(hand_rd),
		.wr_en(s2_go && s2_writes && (s2.dst_pile == pile_hand)),
		.wr_addr(s2.dst_addr),
		.wr_card(s2_card)
	);

	assign store_idle = !s1_valid && !s2_valid;
	assign out_valid = s2_valid && s2.emit;
	assign out_card = s2_card;

	// the sequencer must keep hand traffic inside the 16 slots
	hand_addr_in_range: assert property (@(posedge clk) disable iff (!reset)
		(op.valid && op.ready) |->
			((op.src_pile != pile_hand || op.kind == op_write ||
				pile_size_t'(op.src_addr) < hand_depth) &&
			(op.dst_pile != pile_hand || (op.kind == op_move && !op.copy) ||
				pile_size_t'(op.dst_addr) < hand_depth)));

endmodule

/* logic/pile_sequencer.sv */
`timescale 1ns/1ps

module pile_sequencer
	import card_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	output logic cmd_ready,
	input cmd_code_t cmd_code,
	input card_t cmd_card,
	pile_op_if.seq op,
	input logic store_idle,
	output pile_size_t deck_size,
	output pile_size_t discard_size,
	output pile_size_t hand_size
);

	typedef enum logic [3:0] {
		st_idle,
		st_new_game,
		st_buy,
		st_play_emit,
		st_play_fill,
		st_draw_clear,
		st_draw_deal,
		st_draw_refill,
		st_end_discard,
		st_end_deck,
		st_end_hand
	} state_t;

	state_t state;
	pile_size_t idx; // slot counter for loops
	card_t arg; // buy card or play slot
	logic fire;
	pile_id_t scan_pile;
	pile_size_t scan_size;

	assign cmd_ready = (state == st_idle) && store_idle;
	assign fire = op.valid && op.ready;

	// pile walked by the current endgame phase
	always_comb begin
		case (state)
			st_end_deck: begin
				scan_pile = pile_deck;
				scan_size = deck_size;
			end
			st_end_hand: begin
				scan_pile = pile_hand;
				scan_size = hand_size;
			end
			default: begin
				scan_pile = pile_discard;
				scan_size = discard_size;
			end
		endcase
	end

	always_comb begin
		op.valid = 1'b0;
		op.kind = op_move;
		op.src_pile = pile_hand;
		op.src_addr = pile_addr_t'(idx);
		op.dst_pile = pile_discard;
		op.dst_addr = pile_addr_t'(discard_size); // append to discard
		op.copy = 1'b1;
		op.emit = 1'b0;
		op.data = arg;
		case (state)
			st_new_game: begin
				op.valid = 1'b1;
				op.kind = op_write;
				op.dst_addr = pile_addr_t'(idx);
				op.data = (idx < start_copper_count) ? card_copper : card_estate;
			end
			st_buy: begin
				op.valid = 1'b1;
				op.kind = op_write;
			end
			st_play_emit: begin
				op.valid = 1'b1;
				op.src_addr = pile_addr_t'(arg);
				op.emit = 1'b1;
			end
			st_play_fill: begin // last card closes the gap
				op.valid = 1'b1;
				op.src_addr = pile_addr_t'(hand_size - 8'd1);
				op.dst_pile = pile_hand;
				op.dst_addr = pile_addr_t'(arg);
			end
			st_draw_clear: begin
				op.valid = (hand_size != '0);
			end
			st_draw_deal: begin
				op.valid = (hand_size < hand_limit) && (deck_size != '0);
				op.src_pile = pile_deck;
				op.src_addr = pile_addr_t'(deck_size - 8'd1); // deck top
				op.dst_pile = pile_hand;
				op.dst_addr = pile_addr_t'(hand_size);
			end
			st_draw_refill: begin
				op.valid = (discard_size != '0);
				op.src_pile = pile_discard;
				op.src_addr = pile_addr_t'(deck_size);
				op.dst_pile = pile_deck;
				op.dst_addr = pile_addr_t'(deck_size);
			end
			st_end_discard, st_end_deck, st_end_hand: begin
				op.valid = (idx < scan_size);
				op.src_pile = scan_pile;
				op.copy = 1'b0;
				op.emit = 1'b1;
			end
			default: begin
				op.valid = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready) begin
			arg <= cmd_card;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_idle;
			idx <= '0;
			deck_size <= '0;
			discard_size <= '0;
			hand_size <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (cmd_valid && cmd_ready) begin
						idx <= '0;
						case (cmd_code)
							cmd_new_game: begin
								deck_size <= '0;
								discard_size <= '0;
								hand_size <= '0;
								state <= st_new_game;
							end
							cmd_buy: begin
								if (discard_size < deck_depth) begin // full pile drops it
									state <= st_buy;
								end
							end
							cmd_play: begin
								if (pile_size_t'(cmd_card) < hand_size) begin
									state <= st_play_emit;
								end
							end
							cmd_draw: state <= st_draw_clear;
							cmd_endgame: state <= st_end_discard;
							default: state <= st_idle;
						endcase
					end
				end
				st_new_game: begin
					if (fire) begin
						discard_size <= discard_size + 8'd1;
						idx <= idx + 8'd1;
						if (idx + 8'd1 == start_copper_count + start_estate_count) begin
							state <= st_idle;
						end
					end
				end
				st_buy: begin
					if (fire) begin
						discard_size <= discard_size + 8'd1;
						state <= st_idle;
					end
				end
				st_play_emit: begin
					if (fire) begin
						discard_size <= discard_size + 8'd1;
						state <= st_play_fill;
					end
				end
				st_play_fill: begin
					if (fire) begin
						hand_size <= hand_size - 8'd1;
						state <= st_idle;
					end
				end
				st_draw_clear: begin
					if (hand_size == '0) begin
						state <= st_draw_deal;
					end else if (fire) begin
						idx <= idx + 8'd1;
						hand_size <= hand_size - 8'd1;
						discard_size <= discard_size + 8'd1;
					end
				end
				st_draw_deal: begin
					if (hand_size >= hand_limit ||
						(deck_size == '0 && discard_size == '0)) begin
						state <= st_idle;
					end else if (deck_size == '0) begin
						state <= st_draw_refill;
					end else if (fire) begin
						deck_size <= deck_size - 8'd1;
						hand_size <= hand_size + 8'd1;
					end
				end
				st_draw_refill: begin
					if (discard_size == '0) begin
						state <= st_draw_deal;
					end else if (fire) begin
						deck_size <= deck_size + 8'd1;
						discard_size <= discard_size - 8'd1;
					end
				end
				st_end_discard, st_end_deck, st_end_hand: begin
					if (idx >= scan_size) begin
						idx <= '0;
						case (state)
							st_end_discard: state <= st_end_deck;
							st_end_deck: state <= st_end_hand;
							default: state <= st_idle;
						endcase
					end else if (fire) begin
						idx <= idx + 8'd1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	cmd_code_known: assert property (@(posedge clk) disable iff (!reset)
		cmd_valid |-> cmd_code inside {cmd_new_game, cmd_buy, cmd_play, cmd_draw, cmd_endgame});

	hand_within_depth: assert property (@(posedge clk) disable iff (!reset)
		hand_size <= hand_depth);

endmodule

/* logic/card_stream_out.sv */
`timescale 1ns/1ps

module card_stream_out
	import card_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input card_t in_card,
	output logic card_valid,
	input logic card_ready,
	output card_t card_out
);

	logic [1:0] count; // cards held, 0 to 2
	card_t head; // card on the output
	card_t tail; // card behind it
	logic push;
	logic pop;

	assign in_ready = (count != 2'd2); // registered, no path from card_ready
	assign card_valid = (count != 2'd0);
	assign card_out = head;
	assign push = in_valid && in_ready;
	assign pop = card_valid && card_ready;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= 2'd0;
		end else if (push && !pop) begin
			count <= count + 2'd1;
		end else if (pop && !push) begin
			count <= count - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (push && (count == 2'd0 || (count == 2'd1 && pop))) begin
			head <= in_card; // straight to the output
		end else if (pop) begin
			head <= tail;
		end
		if (push && count == 2'd1 && !pop) begin
			tail <= in_card;
		end
	end

	card_held_stable: assert property (@(posedge clk) disable iff (!reset)
		(card_valid && !card_ready) |=> (card_valid && $stable(card_out)));

endmodule

/* logic/pile_manager_top.sv */
`timescale 1ns/1ps

module pile_manager_top
	import card_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	output logic cmd_ready,
	input cmd_code_t cmd_code,
	input card_t cmd_card,
	output logic card_valid,
	input logic card_ready,
	output card_t card_out,
	output pile_size_t deck_size,
	output pile_size_t discard_size,
	output pile_size_t hand_size
);

	pile_op_if op_bus ();

	logic store_idle;
	logic out_valid;
	logic out_ready;
	card_t out_card;

	pile_sequencer sequencer_i (
		.clk,
		.reset,
		.cmd_valid,
		.cmd_ready,
		.cmd_code,
		.cmd_card,
		.op(op_bus),
		.store_idle,
		.deck_size,
		.discard_size,
		.hand_size
	);

	pile_store store_i (
		.clk,
		.reset,
		.op(op_bus),
		.store_idle,
		.out_valid,
		.out_ready,
		.out_card
	);

	card_stream_out stream_i (
		.clk,
		.reset,
		.in_valid(out_valid),
		.in_ready(out_ready),
		.in_card(out_card),
		.card_valid,
		.card_ready,
		.card_out
	);

endmodule

/* testbench/pile_model.svh */
`ifndef pile_model_svh
`define pile_model_svh

card_t deck_m [128];
card_t discard_m [128];
card_t hand_m [16];
int deck_n = 0;
int discard_n = 0;
int hand_n = 0;

card_t exp_q [$]; // cards the stream still owes
card_t exp_head = card_t'(0); // next card the stream must show
int exp_count = 0;

function automatic void refresh_head();
	exp_count = exp_q.size();
	exp_head = (exp_q.size() != 0) ? exp_q[0] : card_t'(0);
endfunction

function automatic void expect_card(input card_t c);
	exp_q.push_back(c);
	refresh_head();
endfunction

// seven coppers then three estates, all in the discard pile
function automatic void load_starting_piles();
	int total;
	total = int'(start_copper_count) + int'(start_estate_count);
	for (int i = 0; i < total; i++) begin
		discard_m[i] = (i < int'(start_copper_count)) ? card_copper : card_estate;
	end
	discard_n = total;
	deck_n = 0;
	hand_n = 0;
endfunction

function automatic void add_to_discard(input card_t c);
	if (discard_n < int'(deck_depth)) begin // full pile ignores the buy
		discard_m[discard_n] = c;
		discard_n++;
	end
endfunction

function automatic void play_from_hand(input int k);
	if (k < hand_n) begin
		expect_card(hand_m[k]);
		discard_m[discard_n] = hand_m[k];
		discard_n++;
		hand_m[k] = hand_m[hand_n - 1]; // last card fills the gap
		hand_n--;
	end
endfunction

function automatic void draw_hand();
	for (int i = 0; i < hand_n; i++) begin
		discard_m[discard_n] = hand_m[i];
		discard_n++;
	end
	hand_n = 0;
	while (hand_n < int'(hand_limit) && (deck_n != 0 || discard_n != 0)) begin
		if (deck_n == 0) begin // refill keeps discard order
			for (int i = 0; i < discard_n; i++) begin
				deck_m[i] = discard_m[i];
			end
			deck_n = discard_n;
			discard_n = 0;
		end
		hand_m[hand_n] = deck_m[deck_n - 1]; // deck top
		hand_n++;
		deck_n--;
	end
endfunction

// scoring order is discard, deck, hand
function automatic void list_all_cards();
	for (int i = 0; i < discard_n; i++) begin
		expect_card(discard_m[i]);
	end
	for (int i = 0; i < deck_n; i++) begin
		expect_card(deck_m[i]);
	end
	for (int i = 0; i < hand_n; i++) begin
		expect_card(hand_m[i]);
	end
endfunction

`endif

/* testbench/tb_pile_manager.sv */
`timescale 1ns/1ps

module tb_pile_manager
	import card_pkg::*;
();

	localparam int wait_limit = 5000; // cycles per wait

	logic clk;
	logic reset;
	logic cmd_valid;
	logic cmd_ready;
	cmd_code_t cmd_code;
	card_t cmd_card;
	logic card_valid;
	logic card_ready;
	card_t card_out;
	pile_size_t deck_size;
	pile_size_t discard_size;
	pile_size_t hand_size;

	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	string test_name = "startup";
	logic random_ready = 1'b0;
	logic taking = 1'b0; // transfer seen in the last cycle

	`include "pile_model.svh"

	pile_manager_top dut_i (
		.clk,
		.reset,
		.cmd_valid,
		.cmd_ready,
		.cmd_code,
		.cmd_card,
		.card_valid,
		.card_ready,
		.card_out,
		.deck_size,
		.discard_size,
		.hand_size
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		#1;
		card_ready = random_ready ? 1'($urandom) : 1'b1; // consumer stalls in the back-pressure test
	end

	// retire the model's head card once the DUT has handed it over
	always @(negedge clk) begin
		if (taking && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			refresh_head();
		end
		taking = card_valid && card_ready && reset;
	end

	stream_matches_model: assert property (@(posedge clk) disable iff (!reset)
		(card_valid && card_ready) |-> (exp_count != 0 && card_out == exp_head))
	else begin
		errors++;
		if (exp_count == 0) begin
			$display("%s: the DUT streamed a card the model did not expect", test_name);
		end else begin
			$display("Fail %s: card expected %0d actual %0d", test_name, exp_head,
				$sampled(card_out));
		end
	end

	stream_held_stable: assert property (@(posedge clk) disable iff (!reset)
		(card_valid && !card_ready) |=> (card_valid && $stable(card_out)))
	else begin
		errors++;
		$display("%s: card_out changed or vanished while the consumer stalled", test_name);
	end

	task automatic abort_run(input string why);
		$display("%s: %s", test_name, why);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic wait_ready();
		int waited;
		waited = 0;
		while (!cmd_ready && waited < wait_limit) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!cmd_ready) begin
			abort_run("timed out waiting for cmd_ready");
		end
	endtask

	// cmd_ready is stable here, so the transfer lands on the next edge
	task automatic send_cmd(input cmd_code_t code, input card_t card);
		wait_ready();
		cmd_valid = 1'b1;
		cmd_code = code;
		cmd_card = card;
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
		wait_ready();
	endtask

	task automatic buy_random_card();
		card_t card;
		card = card_t'($urandom);
		add_to_discard(card);
		send_cmd(cmd_buy, card);
	endtask

	task automatic wait_stream_drained();
		int waited;
		waited = 0;
		while (exp_count != 0 && waited < wait_limit) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (exp_count != 0) begin
			abort_run("expected cards never came out of the DUT");
		end
		assert (!card_valid) else begin
			errors++;
			$display("%s: the DUT holds a card beyond the expected stream", test_name);
		end
	endtask

	task automatic check_sizes();
		assert (int'(deck_size) == deck_n) else begin
			errors++;
			$display("Fail %s: deck_size expected %0d actual %0d", test_name, deck_n, deck_size);
		end
		assert (int'(discard_size) == discard_n) else begin
			errors++;
			$display("Fail %s: discard_size expected %0d actual %0d", test_name, discard_n,
				discard_size);
		end
		assert (int'(hand_size) == hand_n) else begin
			errors++;
			$display("Fail %s: hand_size expected %0d actual %0d", test_name, hand_n, hand_size);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("passed  %s", test_name);
		end else begin
			tests_failed++;
			$display("FAILED  %s with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic score_all();
		list_all_cards();
		send_cmd(cmd_endgame, card_copper);
		wait_stream_drained();
		check_sizes();
	endtask

	initial begin
		int k;
		void'($urandom(32'hff193f5b));
		reset = 1'b0;
		cmd_valid = 1'b0;
		cmd_code = cmd_new_game;
		cmd_card = card_copper;
		card_ready = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b1;

		start_test("reset_state");
		check_sizes();
		assert (cmd_ready && !card_valid) else begin
			errors++;
			$display("%s: cmd_ready low or card_valid high after reset", test_name);
		end
		end_test();

		start_test("new_game_endgame");
		load_starting_piles();
		send_cmd(cmd_new_game, card_copper);
		check_sizes();
		score_all();
		end_test();

		start_test("buy_random");
		for (int i = 0; i < 6; i++) begin
			buy_random_card();
			check_sizes();
		end
		score_all(); // bought cards close the discard listing
		end_test();

		start_test("draw_after_new_game");
		load_starting_piles();
		send_cmd(cmd_new_game, card_copper);
		draw_hand();
		send_cmd(cmd_draw, card_copper);
		check_sizes();
		draw_hand(); // second draw discards the first hand
		send_cmd(cmd_draw, card_copper);
		check_sizes();
		score_all();
		end_test();

		start_test("play_random_slot");
		load_starting_piles();
		send_cmd(cmd_new_game, card_copper);
		for (int i = 0; i < int'(hand_limit); i++) begin
			buy_random_card();
		end
		draw_hand(); // bought cards sit on the deck top
		send_cmd(cmd_draw, card_copper);
		check_sizes();
		for (int i = 0; i < 3; i++) begin
			k = $urandom % hand_n;
			play_from_hand(k);
			send_cmd(cmd_play, card_t'(k));
			wait_stream_drained();
			check_sizes();
		end
		k = hand_n; // slot past the hand
		play_from_hand(k);
		send_cmd(cmd_play, card_t'(k));
		wait_stream_drained();
		check_sizes();
		score_all();
		end_test();

		start_test("endgame_back_pressure");
		random_ready = 1'b1;
		score_all();
		random_ready = 1'b0;
		end_test();

		$display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+testbench
common/card_pkg.sv
common/pile_op_if.sv
pile_store/card_pile.sv
pile_store/pile_store.sv
logic/pile_sequencer.sv
logic/card_stream_out.sv
logic/pile_manager_top.sv
testbench/tb_pile_manager.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_pile_manager
FLIST = flist.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
